//--- vlog.f
hw/spmv_pkg.sv
hw/sync_fifo.sv
hw/op_ring_ctrl.sv
hw/mem_req_arbiter.sv
hw/mem_port.sv
hw/spmv_pe.sv
verif/spmv_pe_checker.sv
verif/spmv_pe_monitor.sv
verif/tb_spmv_pe.sv

//--- run.sh
#!/usr/bin/env bash
# builds and runs the spmv_pe testbench with verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_spmv_pe -o sim_spmv_pe
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/sim_spmv_pe)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

//--- verif/tb_spmv_pe.sv
module tb_spmv_pe import spmv_pkg::*; ();

    typedef struct packed {
        word_t    op;
        logic     dl;
        addr_t    dl_addr;
        ld_tag_t  dl_tag;
        logic     cl;
        addr_t    cl_addr;
        logic     rp;
        word_t    rdata;
        logic     mp;
        rsp_tag_t mtag;
        word_t    mq;
        logic     stl;
        logic     bsy;
    } entry_t;

    logic     clk, arst_n, busy_in, busy_out;
    word_t    op_in, op_out, result_data, req_mem_d_or_tag, rsp_mem_q, rsp_data;
    logic     dec_ld, dec_ld_stall, cache_ld, cache_ld_stall, result_push, result_stall;
    addr_t    dec_ld_addr, cache_ld_addr, req_mem_addr;
    ld_tag_t  dec_ld_tag, dec_rsp_tag;
    logic     req_mem_ld, req_mem_st, req_mem_stall, rsp_mem_push, rsp_mem_stall;
    rsp_tag_t rsp_mem_tag;
    logic     dec_rsp_push, cache_rsp_push, dec_rsp_stall;
    int       mismatch_count, other_count, pending;
    logic     steady_active;

    entry_t      tbl[$];
    logic        cur_stl, cur_bsy;
    logic        table_built = 1'b0;
    int          seg_a_len;
    int          burst_left = 0;
    logic [31:0] lfsr = 32'had9c_b1b6;

    spmv_pe #(.PE_ID(4'd5), .SRC_DEPTH(32), .REQ_DEPTH(32)) dut0 (.*);

    spmv_pe_monitor #(.PE_ID(4'd5)) mon0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int rand_bits(int n);
        int v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic word_t make_op(logic [2:0] code, logic [3:0] pe, logic bc,
                                      logic [3:0] idx, logic [51:0] data);
        return {data, idx, bc, pe, code};
    endfunction

    function automatic entry_t blank();
        entry_t e = '0;
        e.stl = cur_stl;
        e.bsy = cur_bsy;
        return e;
    endfunction

    function automatic entry_t idle_like(entry_t src);
        entry_t e = '0;
        e.stl = src.stl;
        e.bsy = src.bsy;
        return e;
    endfunction

    task automatic add_op(word_t op);
        entry_t e;
        e = blank();
        e.op = op;
        tbl.push_back(e);
    endtask

    task automatic add_dec(addr_t a, ld_tag_t t);
        entry_t e;
        e = blank();
        e.dl = 1'b1;
        e.dl_addr = a;
        e.dl_tag = t;
        tbl.push_back(e);
    endtask

    task automatic add_cache(addr_t a);
        entry_t e;
        e = blank();
        e.cl = 1'b1;
        e.cl_addr = a;
        tbl.push_back(e);
    endtask

    task automatic add_res(word_t d);
        entry_t e;
        e = blank();
        e.rp = 1'b1;
        e.rdata = d;
        tbl.push_back(e);
    endtask

    task automatic add_rsp(rsp_tag_t t, word_t q);
        entry_t e;
        e = blank();
        e.mp = 1'b1;
        e.mtag = t;
        e.mq = q;
        tbl.push_back(e);
    endtask

    task automatic build_table();
        cur_stl = 1'b0;
        cur_bsy = 1'b1;
        // ring traffic, other pes pass through untouched
        add_op(make_op(3'd2, 4'd3, 1'b0, 4'd0, 52'h111));
        add_op(make_op(3'd3, 4'd3, 1'b0, 4'd1, 52'h0));
        add_op(make_op(3'd5, 4'd9, 1'b0, 4'd2, 52'hf_dead_beef_0000));
        add_op(make_op(3'd2, 4'd5, 1'b0, 4'd2, 52'hf_abcd_0123_4567));
        add_op(make_op(3'd2, 4'd0, 1'b1, 4'd3, 52'h0_1234_5678_9abc));
        add_op(make_op(3'd2, 4'd5, 1'b0, 4'd7, 52'h777));
        add_op('0);
        add_op(make_op(3'd3, 4'd5, 1'b0, 4'd2, 52'h0));
        add_op('0);
        add_op(make_op(3'd3, 4'd1, 1'b1, 4'd3, 52'h0));
        add_op('0);
        // index out of range, the slot behind it survives
        add_op(make_op(3'd3, 4'd5, 1'b0, 4'd6, 52'h0));
        add_op(make_op(3'd0, 4'd2, 1'b0, 4'd0, 52'h55));
        for (int i = 0; i < 4; i++) begin
            add_dec(48'h8000 + 48'(i * 64), ld_tag_t'(i));
            add_cache(48'h4_0000 + 48'(i * 8));
        end
        for (int i = 0; i < 8; i++)
            add_rsp(rsp_tag_t'(i), {32'hc0de_0000 | 32'(i), 32'(i * 3)});
        // store window of five slots
        add_op(make_op(3'd2, 4'd5, 1'b0, 4'd0, 52'h1000));
        add_op(make_op(3'd2, 4'd5, 1'b0, 4'd1, 52'h1028));
        repeat (3) add_op('0);
        for (int i = 0; i < 7; i++)
            add_res(64'hd000_0000_0000_0000 + 64'(i));
        add_dec(48'h9000, 2'd1);
        repeat (4) add_op('0);
        add_op(make_op(3'd3, 4'd5, 1'b0, 4'd0, 52'h0));
        add_op('0);
        // steady entered with requests held back
        cur_bsy = 1'b0;
        repeat (2) add_op('0);
        cur_stl = 1'b1;
        repeat (2) add_op('0);
        add_dec(48'ha000, 2'd2);
        add_cache(48'h4_1000);
        add_dec(48'ha040, 2'd3);
        add_op(make_op(3'd4, 4'd5, 1'b0, 4'd0, 52'h0));
        repeat (3) add_op('0);
        cur_stl = 1'b0;
        repeat (2) add_op('0);
        seg_a_len = tbl.size();
        // soft reset drops requests still queued
        cur_stl = 1'b1;
        repeat (2) add_op('0);
        add_dec(48'hb000, 2'd0);
        add_cache(48'h4_2000);
        add_dec(48'hb100, 2'd1);
        repeat (2) add_op('0);
        add_op(make_op(3'd1, 4'd5, 1'b0, 4'd0, 52'h0));
        repeat (4) add_op('0);
        cur_stl = 1'b0;
        repeat (4) add_op('0);
        add_op(make_op(3'd3, 4'd5, 1'b0, 4'd0, 52'h0));
        repeat (7) add_op('0);
    endtask

    task automatic drive(entry_t e);
        logic stall;
        @(posedge clk);
        if (burst_left > 0)
            burst_left--;
        else if (rand_bits(3) == 0)
            burst_left = 1 + rand_bits(2);
        stall = e.stl || (burst_left > 0);
        op_in         <= e.op;
        dec_ld        <= e.dl;
        dec_ld_addr   <= e.dl_addr;
        dec_ld_tag    <= e.dl_tag;
        cache_ld      <= e.cl;
        cache_ld_addr <= e.cl_addr;
        result_push   <= e.rp;
        result_data   <= e.rdata;
        rsp_mem_push  <= e.mp;
        rsp_mem_tag   <= e.mtag;
        rsp_mem_q     <= e.mq;
        req_mem_stall <= stall;
        busy_in       <= e.bsy && (rand_bits(1) == 1);
        dec_rsp_stall <= (rand_bits(1) == 1);
    endtask

    // the monitor sees a push one edge late, so idle a little first
    task automatic wait_drained();
        entry_t e;
        e = '0;
        repeat (4) drive(e);
        while (pending != 0 || steady_active)
            drive(e);
    endtask

    initial begin
        int gap;
        int total;
        entry_t e;
        arst_n = 1'b0;
        op_in = '0;
        busy_in = 1'b0;
        {dec_ld, cache_ld, result_push, rsp_mem_push, req_mem_stall, dec_rsp_stall} = '0;
        dec_ld_addr = '0;
        dec_ld_tag = '0;
        cache_ld_addr = '0;
        result_data = '0;
        rsp_mem_tag = '0;
        rsp_mem_q = '0;
        build_table();
        table_built = 1'b1;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < tbl.size(); i++) begin
            e = tbl[i];
            drive(e);
            gap = rand_bits(2);
            repeat (gap) drive(idle_like(e));
            if (i == seg_a_len - 1)
                wait_drained();
        end
        wait_drained();
        total = mismatch_count + other_count + dut0.chk0.fail_count;
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_count, other_count, dut0.chk0.fail_count);
        if (total == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        wait (table_built);
        repeat (tbl.size() * 40 + 500) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", tbl.size() * 40 + 500);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- verif/spmv_pe_monitor.sv
module spmv_pe_monitor import spmv_pkg::*; #(
    parameter pe_id_t PE_ID = 4'd5
) (
    input  logic     clk,
    input  logic     arst_n,
    input  word_t    op_in,
    input  word_t    op_out,
    input  logic     busy_in,
    input  logic     busy_out,
    input  logic     dec_ld,
    input  addr_t    dec_ld_addr,
    input  ld_tag_t  dec_ld_tag,
    input  logic     dec_ld_stall,
    input  logic     cache_ld,
    input  addr_t    cache_ld_addr,
    input  logic     cache_ld_stall,
    input  logic     result_push,
    input  word_t    result_data,
    input  logic     result_stall,
    input  logic     req_mem_ld,
    input  logic     req_mem_st,
    input  addr_t    req_mem_addr,
    input  word_t    req_mem_d_or_tag,
    input  logic     rsp_mem_push,
    input  rsp_tag_t rsp_mem_tag,
    input  word_t    rsp_mem_q,
    input  logic     rsp_mem_stall,
    input  logic     dec_rsp_push,
    input  ld_tag_t  dec_rsp_tag,
    input  logic     cache_rsp_push,
    input  word_t    rsp_data,
    input  logic     dec_rsp_stall,
    output int       mismatch_count,
    output int       other_count,
    output int       pending,
    output logic     steady_active
);

    word_t    h1, h2, exp_op, rsp_q_p;
    pe_reg_t  mregs [4];
    logic     bi1, bi2, rsp_p, rsp_stall_p, busy_p, steady_seen;
    rsp_tag_t rsp_tag_p;
    int       cyc, last_req_cyc;
    int       n_mis = 0;
    int       n_other = 0;
    addr_t    dec_addr_q[$], cache_addr_q[$], st_addr_q[$];
    ld_tag_t  dec_tag_q[$];
    word_t    st_data_q[$];

    assign mismatch_count = n_mis;
    assign other_count    = n_other;

    function automatic logic hits(word_t op);
        return op[7] || (op[6:3] == PE_ID);
    endfunction

    task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            n_mis++;
            $display("MISMATCH %s: got %h expected %h (cycle %0d)", name, got, exp, cyc);
        end
    endtask

    task automatic report(string what);
        n_other++;
        $display("ERROR cycle %0d: %s", cyc, what);
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            h1 = '0;
            h2 = '0;
            exp_op = '0;
            for (int i = 0; i < 4; i++)
                mregs[i] = '0;
            {bi1, bi2, rsp_p, rsp_stall_p, busy_p, steady_seen} = '0;
            cyc = 0;
            last_req_cyc = 0;
            dec_addr_q.delete();
            dec_tag_q.delete();
            cache_addr_q.delete();
            st_addr_q.delete();
            st_data_q.delete();
        end else begin
            cyc++;
            check_val("op_out", op_out, exp_op);
            if (!steady_seen) begin
                check_val("busy_out", 64'(busy_out), 64'(bi2));
            end else if (busy_p && !busy_out) begin
                // 32 quiet cycles plus the fsm and busy register delay
                if (cyc - last_req_cyc < 32 || cyc - last_req_cyc > 40)
                    report($sformatf("busy_out fell %0d cycles after the last request",
                                     cyc - last_req_cyc));
                steady_seen = 1'b0;
            end

            // the table never brings a source queue near its almost-full level
            check_val("dec_ld_stall", 64'(dec_ld_stall), 64'd0);
            check_val("cache_ld_stall", 64'(cache_ld_stall), 64'd0);
            check_val("result_stall", 64'(result_stall), 64'd0);

            // responses lag the memory side by one cycle
            check_val("dec_rsp_push", 64'(dec_rsp_push), 64'(rsp_p && !rsp_tag_p[0]));
            check_val("cache_rsp_push", 64'(cache_rsp_push), 64'(rsp_p && rsp_tag_p[0]));
            if (rsp_p) begin
                check_val("rsp_data", rsp_data, rsp_q_p);
                if (!rsp_tag_p[0])
                    check_val("dec_rsp_tag", 64'(dec_rsp_tag), 64'(rsp_tag_p[2:1]));
            end
            check_val("rsp_mem_stall", 64'(rsp_mem_stall), 64'(rsp_stall_p));

            if (req_mem_ld || req_mem_st)
                last_req_cyc = cyc;
            if (req_mem_ld && req_mem_d_or_tag[0]) begin
                if (cache_addr_q.size() == 0) begin
                    report("cache load request with none outstanding");
                end else begin
                    check_val("req_mem_addr", 64'(req_mem_addr), 64'(cache_addr_q.pop_front()));
                    check_val("req_mem_d_or_tag", req_mem_d_or_tag, 64'd1);
                end
            end else if (req_mem_ld) begin
                if (dec_addr_q.size() == 0) begin
                    report("decoder load request with none outstanding");
                end else begin
                    check_val("req_mem_addr", 64'(req_mem_addr), 64'(dec_addr_q.pop_front()));
                    check_val("req_mem_d_or_tag", req_mem_d_or_tag,
                              64'({dec_tag_q.pop_front(), 1'b0}));
                end
            end
            if (req_mem_st) begin
                if (st_addr_q.size() == 0) begin
                    report("store request with none outstanding");
                end else begin
                    check_val("req_mem_addr", 64'(req_mem_addr), 64'(st_addr_q.pop_front()));
                    check_val("req_mem_d_or_tag", req_mem_d_or_tag, st_data_q.pop_front());
                end
            end

            // decode in the ring model sits two slots behind op_in
            if (hits(h2) && h2[2:0] == 3'd3 && h2[11:8] < 4'd4)
                exp_op = {4'd0, mregs[h2[9:8]], h2[11:8], 1'b0, PE_ID, 3'd5};
            else
                exp_op = h1;
            if (hits(h2) && h2[2:0] == 3'd2 && h2[11:8] < 4'd4)
                mregs[h2[9:8]] = h2[59:12];
            if (hits(h2) && h2[2:0] == 3'd1) begin
                dec_addr_q.delete();
                dec_tag_q.delete();
                cache_addr_q.delete();
                st_addr_q.delete();
                st_data_q.delete();
            end
            if (hits(op_in) && op_in[2:0] == 3'd4)
                steady_seen = 1'b1;
            h2 = h1;
            h1 = op_in;

            if (dec_ld) begin
                dec_addr_q.push_back(dec_ld_addr);
                dec_tag_q.push_back(dec_ld_tag);
            end
            if (cache_ld)
                cache_addr_q.push_back(cache_ld_addr);
            // a result is stored only while the pointer has not reached its end
            if (result_push && mregs[0] != mregs[1]) begin
                st_addr_q.push_back(mregs[0]);
                st_data_q.push_back(result_data);
                mregs[0] = mregs[0] + 48'd8;
            end

            bi2 = bi1;
            bi1 = busy_in;
            busy_p = busy_out;
            rsp_p = rsp_mem_push;
            rsp_tag_p = rsp_mem_tag;
            rsp_q_p = rsp_mem_q;
            rsp_stall_p = dec_rsp_stall;
        end
        pending <= dec_addr_q.size() + cache_addr_q.size() + st_addr_q.size();
        steady_active <= steady_seen;
    end

endmodule

//--- verif/spmv_pe_checker.sv
module spmv_pe_checker (
    input logic clk,
    input logic arst_n,
    input logic req_mem_ld,
    input logic req_mem_st,
    input logic req_mem_stall,
    input logic busy_out
);

    int fail_count = 0;

    // one request kind per cycle
    assert property (@(posedge clk) disable iff (!arst_n) !(req_mem_ld && req_mem_st))
    else begin
        fail_count++;
        $error("load and store request in the same cycle");
    end

    // the registered stall lets at most two requests through
    assert property (@(posedge clk) disable iff (!arst_n)
        (req_mem_stall && $past(req_mem_stall) && $past(req_mem_stall, 2))
        |-> !(req_mem_ld || req_mem_st))
    else begin
        fail_count++;
        $error("request in the third cycle of a memory stall");
    end

    assert property (@(posedge clk) $rose(arst_n) |-> !busy_out)
    else begin
        fail_count++;
        $error("busy_out high in the first cycle after reset");
    end

endmodule

bind spmv_pe spmv_pe_checker chk0 (.*);

//--- hw/spmv_pe.sv
module spmv_pe import spmv_pkg::*; #(
    parameter pe_id_t PE_ID     = '0,
    parameter int     SRC_DEPTH = 32,
    parameter int     REQ_DEPTH = 32
) (
    input  logic     clk,
    input  logic     arst_n,
    input  word_t    op_in,
    output word_t    op_out,
    input  logic     busy_in,
    output logic     busy_out,
    input  logic     dec_ld,
    input  addr_t    dec_ld_addr,
    input  ld_tag_t  dec_ld_tag,
    output logic     dec_ld_stall,
    input  logic     cache_ld,
    input  addr_t    cache_ld_addr,
    output logic     cache_ld_stall,
    input  logic     result_push,
    input  word_t    result_data,
    output logic     result_stall,
    output logic     req_mem_ld,
    output logic     req_mem_st,
    output addr_t    req_mem_addr,
    output word_t    req_mem_d_or_tag,
    input  logic     req_mem_stall,
    input  logic     rsp_mem_push,
    input  rsp_tag_t rsp_mem_tag,
    input  word_t    rsp_mem_q,
    output logic     rsp_mem_stall,
    output logic     dec_rsp_push,
    output ld_tag_t  dec_rsp_tag,
    output logic     cache_rsp_push,
    output word_t    rsp_data,
    input  logic     dec_rsp_stall
);

    logic  soft_rst;
    logic  store_en;
    logic  store_issued;
    logic  queues_idle;
    logic  req_arb_stall;
    logic  fwd_ld;
    logic  fwd_st;
    addr_t store_addr;
    addr_t fwd_addr;
    word_t fwd_d_or_tag;

    op_ring_ctrl #(.PE_ID(PE_ID)) ctrl0 (
        .clk(clk), .arst_n(arst_n), .op_in(op_in), .op_out(op_out),
        .busy_in(busy_in), .busy_out(busy_out), .store_issued(store_issued),
        .queues_idle(queues_idle), .soft_rst(soft_rst),
        .store_addr(store_addr), .store_en(store_en)
    );

    mem_req_arbiter #(.SRC_DEPTH(SRC_DEPTH)) arb0 (
        .clk(clk), .arst_n(arst_n), .soft_rst(soft_rst),
        .dec_ld(dec_ld), .dec_ld_addr(dec_ld_addr), .dec_ld_tag(dec_ld_tag),
        .cache_ld(cache_ld), .cache_ld_addr(cache_ld_addr),
        .result_push(result_push), .result_data(result_data),
        .dec_ld_stall(dec_ld_stall), .cache_ld_stall(cache_ld_stall),
        .result_stall(result_stall), .store_addr(store_addr), .store_en(store_en),
        .req_arb_stall(req_arb_stall), .store_issued(store_issued),
        .fwd_ld(fwd_ld), .fwd_st(fwd_st), .fwd_addr(fwd_addr), .fwd_d_or_tag(fwd_d_or_tag)
    );

    mem_port #(.REQ_DEPTH(REQ_DEPTH)) port0 (
        .clk(clk), .arst_n(arst_n), .soft_rst(soft_rst),
        .fwd_ld(fwd_ld), .fwd_st(fwd_st), .fwd_addr(fwd_addr), .fwd_d_or_tag(fwd_d_or_tag),
        .req_arb_stall(req_arb_stall), .queues_idle(queues_idle),
        .req_mem_ld(req_mem_ld), .req_mem_st(req_mem_st), .req_mem_addr(req_mem_addr),
        .req_mem_d_or_tag(req_mem_d_or_tag), .req_mem_stall(req_mem_stall),
        .rsp_mem_push(rsp_mem_push), .rsp_mem_tag(rsp_mem_tag), .rsp_mem_q(rsp_mem_q),
        .rsp_mem_stall(rsp_mem_stall), .dec_rsp_push(dec_rsp_push),
        .dec_rsp_tag(dec_rsp_tag), .cache_rsp_push(cache_rsp_push),
        .rsp_data(rsp_data), .dec_rsp_stall(dec_rsp_stall)
    );

endmodule

//--- hw/mem_port.sv
module mem_port import spmv_pkg::*; #(
    parameter int REQ_DEPTH = 32
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     soft_rst,
    input  logic     fwd_ld,
    input  logic     fwd_st,
    input  addr_t    fwd_addr,
    input  word_t    fwd_d_or_tag,
    output logic     req_arb_stall,
    output logic     queues_idle,
    output logic     req_mem_ld,
    output logic     req_mem_st,
    output addr_t    req_mem_addr,
    output word_t    req_mem_d_or_tag,
    input  logic     req_mem_stall,
    input  logic     rsp_mem_push,
    input  rsp_tag_t rsp_mem_tag,
    input  word_t    rsp_mem_q,
    output logic     rsp_mem_stall,
    output logic     dec_rsp_push,
    output ld_tag_t  dec_rsp_tag,
    output logic     cache_rsp_push,
    output word_t    rsp_data,
    input  logic     dec_rsp_stall
);

    localparam int REQ_W = $bits(word_t) + $bits(addr_t) + 2;

    logic [REQ_W-1:0] req_q;
    logic             req_empty;
    logic             req_pop;
    logic             req_mem_stall_r;
    logic             rsp_push_r;
    rsp_tag_t         rsp_tag_r;

    // entry layout is data | addr | st | ld
    sync_fifo #(.WIDTH(REQ_W), .DEPTH(REQ_DEPTH), .ALMOST_FULL_COUNT(4)) req_fifo (
        .clk(clk), .arst_n(arst_n), .flush(soft_rst),
        .push(fwd_ld || fwd_st), .pop(req_pop),
        .d({fwd_d_or_tag, fwd_addr, fwd_st, fwd_ld}), .q(req_q),
        .full(), .empty(req_empty), .almost_full(req_arb_stall)
    );

    assign req_pop     = !req_empty && !req_mem_stall_r;
    assign queues_idle = req_empty && !fwd_ld && !fwd_st;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_mem_stall_r <= 1'b0;
            req_mem_ld      <= 1'b0;
            req_mem_st      <= 1'b0;
            rsp_mem_stall   <= 1'b0;
            rsp_push_r      <= 1'b0;
        end else begin
            req_mem_stall_r <= req_mem_stall;
            req_mem_ld      <= req_pop && req_q[0];
            req_mem_st      <= req_pop && req_q[1];
            rsp_mem_stall   <= dec_rsp_stall;
            rsp_push_r      <= rsp_mem_push;
        end
    end

    always_ff @(posedge clk) begin
        req_mem_addr     <= req_q[2 +: $bits(addr_t)];
        req_mem_d_or_tag <= req_q[REQ_W-1 -: $bits(word_t)];
        rsp_tag_r        <= rsp_mem_tag;
        rsp_data         <= rsp_mem_q;
    end

    // tag bit 0 set means the response belongs to the cache
    assign dec_rsp_push   = rsp_push_r && !rsp_tag_r[0];
    assign cache_rsp_push = rsp_push_r && rsp_tag_r[0];
    assign dec_rsp_tag    = rsp_tag_r[2:1];

endmodule

//--- hw/mem_req_arbiter.sv
module mem_req_arbiter import spmv_pkg::*; #(
    parameter int SRC_DEPTH = 32
) (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    soft_rst,
    input  logic    dec_ld,
    input  addr_t   dec_ld_addr,
    input  ld_tag_t dec_ld_tag,
    input  logic    cache_ld,
    input  addr_t   cache_ld_addr,
    input  logic    result_push,
    input  word_t   result_data,
    output logic    dec_ld_stall,
    output logic    cache_ld_stall,
    output logic    result_stall,
    input  addr_t   store_addr,
    input  logic    store_en,
    input  logic    req_arb_stall,
    output logic    store_issued,
    output logic    fwd_ld,
    output logic    fwd_st,
    output addr_t   fwd_addr,
    output word_t   fwd_d_or_tag
);

    localparam int DEC_W = $bits(addr_t) + $bits(ld_tag_t);

    logic             res_empty, res_af, res_pop;
    logic             cache_empty, cache_af, cache_pop;
    logic             dec_empty, dec_af, dec_pop;
    word_t            res_q;
    addr_t            cache_q;
    logic [DEC_W-1:0] dec_q;
    logic             cache_af_r;

    // popped item, held for one cycle
    logic    stage_res, stage_cache, stage_dec;
    word_t   stage_word;
    addr_t   stage_addr;
    ld_tag_t stage_tag;

    sync_fifo #(.WIDTH($bits(word_t)), .DEPTH(SRC_DEPTH), .ALMOST_FULL_COUNT(8)) res_fifo (
        .clk(clk), .arst_n(arst_n), .flush(soft_rst),
        .push(result_push), .pop(res_pop), .d(result_data), .q(res_q),
        .full(), .empty(res_empty), .almost_full(res_af)
    );

    sync_fifo #(.WIDTH($bits(addr_t)), .DEPTH(SRC_DEPTH), .ALMOST_FULL_COUNT(8)) cache_fifo (
        .clk(clk), .arst_n(arst_n), .flush(soft_rst),
        .push(cache_ld), .pop(cache_pop), .d(cache_ld_addr), .q(cache_q),
        .full(), .empty(cache_empty), .almost_full(cache_af)
    );

    sync_fifo #(.WIDTH(DEC_W), .DEPTH(SRC_DEPTH), .ALMOST_FULL_COUNT(3)) dec_fifo (
        .clk(clk), .arst_n(arst_n), .flush(soft_rst),
        .push(dec_ld), .pop(dec_pop), .d({dec_ld_addr, dec_ld_tag}), .q(dec_q),
        .full(), .empty(dec_empty), .almost_full(dec_af)
    );

    // fixed priority, results then cache then decoder
    assign res_pop   = !req_arb_stall && !res_empty;
    assign cache_pop = !req_arb_stall && res_empty && !cache_empty;
    assign dec_pop   = !req_arb_stall && res_empty && cache_empty && !dec_empty;

    assign result_stall = res_af;
    assign store_issued = stage_res && store_en && !soft_rst;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_res      <= 1'b0;
            stage_cache    <= 1'b0;
            stage_dec      <= 1'b0;
            fwd_ld         <= 1'b0;
            fwd_st         <= 1'b0;
            dec_ld_stall   <= 1'b0;
            cache_af_r     <= 1'b0;
            cache_ld_stall <= 1'b0;
        end else begin
            stage_res      <= res_pop && !soft_rst;
            stage_cache    <= cache_pop && !soft_rst;
            stage_dec      <= dec_pop && !soft_rst;
            fwd_st         <= store_issued;
            fwd_ld         <= (stage_cache || stage_dec) && !soft_rst;
            dec_ld_stall   <= dec_af;
            cache_af_r     <= cache_af;
            cache_ld_stall <= cache_af_r;
        end
    end

    always_ff @(posedge clk) begin
        if (res_pop)
            stage_word <= res_q;
        if (cache_pop)
            stage_addr <= cache_q;
        if (dec_pop) begin
            stage_addr <= dec_q[DEC_W-1 -: $bits(addr_t)];
            stage_tag  <= dec_q[$bits(ld_tag_t)-1:0];
        end
    end

    // tag bit 0 tells cache loads from decoder loads
    always_ff @(posedge clk) begin
        if (stage_res) begin
            fwd_addr     <= store_addr;
            fwd_d_or_tag <= stage_word;
        end else if (stage_cache) begin
            fwd_addr     <= stage_addr;
            fwd_d_or_tag <= word_t'(1);
        end else begin
            fwd_addr     <= stage_addr;
            fwd_d_or_tag <= word_t'({stage_tag, 1'b0});
        end
    end

endmodule

//--- hw/op_ring_ctrl.sv
module op_ring_ctrl import spmv_pkg::*; #(
    parameter pe_id_t PE_ID = '0
) (
    input  logic  clk,
    input  logic  arst_n,
    input  word_t op_in,
    output word_t op_out,
    input  logic  busy_in,
    output logic  busy_out,
    input  logic  store_issued,
    input  logic  queues_idle,
    output logic  soft_rst,
    output addr_t store_addr,
    output logic  store_en
);

    localparam int REG_SEL_W = $clog2(NUM_PE_REGS);
    localparam int MSB_Q     = STEADY_TIMEOUT_BITS - 1;

    word_t                          op_in_r;
    word_t                          op_r;
    pe_reg_t                        regs [NUM_PE_REGS];
    pe_state_t                      state;
    logic [STEADY_TIMEOUT_BITS-1:0] quiet_cnt;
    logic                           busy_in_r;

    opcode_t  op_code;
    reg_idx_t op_idx;
    logic     op_hit;
    logic     idx_ok;
    logic     dec_rst;
    logic     dec_ld;
    logic     dec_read;
    logic     dec_steady;
    word_t    ret_op;

    // decode stage looks at the op one ring slot behind op_in_r
    assign op_code = opcode_t'(op_r[OP_ARG_PE-1:0]);
    assign op_idx  = op_r[OP_ARG_2-1:OP_ARG_1];
    assign op_hit  = op_r[OP_ARG_1-1] || (op_r[OP_ARG_1-2:OP_ARG_PE] == PE_ID);
    assign idx_ok  = (op_idx < reg_idx_t'(NUM_PE_REGS));

    assign dec_rst    = op_hit && (op_code == OP_RST);
    assign dec_ld     = op_hit && (op_code == OP_LD) && idx_ok;
    assign dec_read   = op_hit && (op_code == OP_READ) && idx_ok;
    assign dec_steady = op_hit && (op_code == OP_STEADY);

    // answer to a read, data field zero extended
    always_comb begin
        ret_op                          = '0;
        ret_op[OP_ARG_PE-1:0]           = OP_RETURN;
        ret_op[OP_ARG_1-2:OP_ARG_PE]    = PE_ID;
        ret_op[OP_ARG_2-1:OP_ARG_1]     = op_idx;
        ret_op[OP_ARG_2 +: $bits(pe_reg_t)] = regs[op_idx[REG_SEL_W-1:0]];
    end

    assign store_addr = regs[0];
    assign store_en   = (regs[0] != regs[1]);

    // two stage ring, a read replaces the slot behind it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_in_r <= '0;
            op_r    <= '0;
            op_out  <= '0;
        end else begin
            op_in_r <= op_in;
            op_r    <= op_in_r;
            if (dec_read)
                op_out <= ret_op;
            else
                op_out <= op_in_r;
        end
    end

    // register file, a load wins over the store pointer step
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_PE_REGS; i++)
                regs[i] <= '0;
        end else begin
            if (store_issued)
                regs[0] <= regs[0] + pe_reg_t'(STORE_STRIDE);
            if (dec_ld)
                regs[op_idx[REG_SEL_W-1:0]] <= op_r[OP_ARG_2 +: $bits(pe_reg_t)];
        end
    end

    // idle / steady fsm
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= PE_IDLE;
            soft_rst <= 1'b0;
        end else begin
            soft_rst <= dec_rst;
            if (dec_rst)
                state <= PE_IDLE;
            else if (dec_steady)
                state <= PE_STEADY;
            else if (state == PE_STEADY && quiet_cnt[MSB_Q])
                state <= PE_IDLE;
        end
    end

    // counts cycles with nothing left to store or send, holds at the msb
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            quiet_cnt <= '0;
        else if (store_en || !queues_idle)
            quiet_cnt <= '0;
        else if (!quiet_cnt[MSB_Q])
            quiet_cnt <= quiet_cnt + 1'b1;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_in_r <= 1'b0;
            busy_out  <= 1'b0;
        end else begin
            busy_in_r <= busy_in;
            busy_out  <= busy_in_r || (state == PE_STEADY);
        end
    end

endmodule

//--- hw/sync_fifo.sv
module sync_fifo #(
    parameter int WIDTH             = 64,
    parameter int DEPTH             = 32,
    parameter int ALMOST_FULL_COUNT = 4
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             flush,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] d,
    output logic [WIDTH-1:0] q,
    output logic             full,
    output logic             empty,
    output logic             almost_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;

    logic [WIDTH-1:0] mem [DEPTH];
    ptr_t             rd_ptr;
    ptr_t             wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic ptr_t next_ptr(ptr_t p);
        return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // a push into a full queue only lands when the head leaves
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);

    assign q           = mem[rd_ptr];
    assign empty       = (count == '0);
    assign full        = (count == CNT_W'(DEPTH));
    assign almost_full = (int'(count) >= DEPTH - ALMOST_FULL_COUNT);

    always_ff @(posedge clk) begin
        if (do_push && !flush)
            mem[wr_ptr] <= d;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

endmodule

//--- hw/spmv_pkg.sv
package spmv_pkg;

    // memory side widths
    typedef logic [47:0] addr_t;
    typedef logic [63:0] word_t;

    // pe register file
    typedef logic [47:0] pe_reg_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [3:0]  pe_id_t;

    // tags on the memory bus
    typedef logic [1:0] ld_tag_t;
    typedef logic [2:0] rsp_tag_t;

    typedef enum logic [2:0] {
        OP_NOP    = 3'd0,
        OP_RST    = 3'd1,
        OP_LD     = 3'd2,
        OP_READ   = 3'd3,
        OP_STEADY = 3'd4,
        OP_RETURN = 3'd5
    } opcode_t;

    typedef enum logic {
        PE_IDLE,
        PE_STEADY
    } pe_state_t;

    // op word layout, opcode | pe id | bcast | reg idx | data
    localparam int OP_ARG_PE = 3;
    localparam int OP_ARG_1  = 8;
    localparam int OP_ARG_2  = 12;

    localparam int NUM_PE_REGS  = 4;
    localparam int STORE_STRIDE = 8;

    // msb of the quiet counter ends steady state
    localparam int STEADY_TIMEOUT_BITS = 6;

endpackage
